// File: irq_gen_cfg.svh
`ifndef IRQ_GEN_CFG_SVH
`define IRQ_GEN_CFG_SVH

//////////////////////////////////////////////////
// Request word
//////////////////////////////////////////////////

// One bit per interrupt id
`define IRQ_WORD_W 64

//////////////////////////////////////////////////
// Random delay
//////////////////////////////////////////////////

// Width of the delay bounds and of the down-counter
`define IRQ_DLY_W 16

//////////////////////////////////////////////////
// Pseudo-random source
//////////////////////////////////////////////////

// Reset state of the LFSR, must never be zero
`define IRQ_LFSR_SEED 64'h5A3C_96E1_0F87_D24B
// Right-shift Galois mask for x^64 + x^63 + x^61 + x^60 + 1
`define IRQ_LFSR_TAPS 64'hD800_0000_0000_0000

`endif

// File: irq_gen_pkg.sv
`include "irq_gen_cfg.svh"

package irq_gen_pkg;

  //////////////////////////////////////////////////
  // Generator policy
  //////////////////////////////////////////////////

  // Encoding follows the software view of the mode register
  typedef enum logic [1:0] {
    STANDARD         = 2'd0,
    RANDOM           = 2'd1,
    PC_TRIG          = 2'd2,
    SOFTWARE_DEFINED = 2'd3
  } irq_mode_e;

  //////////////////////////////////////////////////
  // Core interrupt bundle
  //////////////////////////////////////////////////

  // 51 lines in total
  typedef struct packed {
    logic        sw;
    logic        timer;
    logic        ext;
    logic [14:0] fast;
    logic        nmi;
    logic [31:0] fastx;
  } irq_lines_t;

  // Static configuration, only changed while in STANDARD
  // Expects min_cycles <= max_cycles and min_id <= max_id
  typedef struct packed {
    logic [`IRQ_DLY_W-1:0] min_cycles;
    logic [`IRQ_DLY_W-1:0] max_cycles;
    logic [5:0]            min_id;
    logic [5:0]            max_id;
    logic [31:0]           pc_trig;
  } irq_cfg_t;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  // DRAW, WAIT and HOLD belong to RANDOM
  // PC_WATCH and PC_ARMED belong to PC_TRIG
  typedef enum logic [2:0] {
    IDLE,
    DRAW,
    WAIT,
    HOLD,
    PC_WATCH,
    PC_ARMED,
    SD_FOLLOW
  } irq_state_e;

endpackage

// File: irq_lfsr_word.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module irq_lfsr_word (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   step_i,
  output logic [`IRQ_WORD_W-1:0] word_o
);

  //////////////////////////////////////////////////
  // Galois shift register
  //////////////////////////////////////////////////

  logic [`IRQ_WORD_W-1:0] lfsr_q;
  logic [`IRQ_WORD_W-1:0] lfsr_d;
  logic                   fb;

  // Bit 0 is shifted out and fed back into the tap positions
  assign fb = lfsr_q[0];

  always_comb begin
    lfsr_d = lfsr_q;
    // Advance only on request so runs repeat from reset
    if (step_i) begin
      lfsr_d = {1'b0, lfsr_q[`IRQ_WORD_W-1:1]};
      if (fb) begin
        lfsr_d = lfsr_d ^ `IRQ_LFSR_TAPS;
      end
    end
  end

  // Seed is non-zero so the sequence never locks up
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `IRQ_LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Whole state is the request word
  // Low bits double as the delay offset
  assign word_o = lfsr_q;

endmodule

// File: irq_delay_timer.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module irq_delay_timer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_i,
  input  logic [`IRQ_DLY_W-1:0] value_i,
  output logic                  expired_o
);

  //////////////////////////////////////////////////
  // Down-counter
  //////////////////////////////////////////////////

  logic [`IRQ_DLY_W-1:0] cnt_q;
  // Set by a load, dropped once zero has been reported
  logic                  run_q;

  // A load of N reports expiry N+1 cycles after the loading edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      run_q <= 1'b0;
    end else if (load_i) begin
      // Reload wins over an ongoing count
      cnt_q <= value_i;
      run_q <= 1'b1;
    end else if (run_q) begin
      if (cnt_q == '0) begin
        // Expiry seen this cycle, go idle
        run_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Expiry
  //////////////////////////////////////////////////

  // Single-cycle pulse while armed and at zero
  assign expired_o = run_q && (cnt_q == '0);

endmodule

// File: irq_line_mapper.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module irq_line_mapper (
  input  logic [`IRQ_WORD_W-1:0]  word_i,
  input  logic                    apply_win_i,
  input  logic [5:0]              min_id_i,
  input  logic [5:0]              max_id_i,
  output irq_gen_pkg::irq_lines_t lines_o,
  output logic                    nz_o,
  output logic [5:0]              top_id_o
);

  // Word bits that reach a core line
  // ids 3, 7, 11 and 16 up to 63
  localparam logic [`IRQ_WORD_W-1:0] MAP_MASK = 64'hFFFF_FFFF_FFFF_0888;

  logic [`IRQ_WORD_W-1:0] win_mask;
  logic [`IRQ_WORD_W-1:0] eff_word;

  //////////////////////////////////////////////////
  // Id window
  //////////////////////////////////////////////////

  // Window only applies to the random word
  always_comb begin
    for (int i = 0; i < `IRQ_WORD_W; i++) begin
      win_mask[i] = !apply_win_i || ((6'(i) >= min_id_i) && (6'(i) <= max_id_i));
    end
  end

  assign eff_word = word_i & win_mask & MAP_MASK;

  //////////////////////////////////////////////////
  // Fold onto the bundle
  //////////////////////////////////////////////////

  assign lines_o.sw    = eff_word[3];
  assign lines_o.timer = eff_word[7];
  assign lines_o.ext   = eff_word[11];
  assign lines_o.fast  = eff_word[30:16];
  assign lines_o.nmi   = eff_word[31];
  assign lines_o.fastx = eff_word[63:32];

  // Any mapped line requested
  assign nz_o = |eff_word;

  // Highest set mapped id
  // The last hit in the scan wins
  always_comb begin
    top_id_o = '0;
    for (int i = 0; i < `IRQ_WORD_W; i++) begin
      if (eff_word[i]) begin
        top_id_o = 6'(i);
      end
    end
  end

endmodule

// File: irq_mode_fsm.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module irq_mode_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  irq_gen_pkg::irq_mode_e mode_i,
  input  irq_gen_pkg::irq_cfg_t  cfg_i,
  input  logic [31:0]            pc_i,
  input  logic                   pc_valid_i,
  input  logic [`IRQ_WORD_W-1:0] lines_i,
  input  logic                   irq_ack_i,
  input  logic                   word_nz_i,
  input  logic                   dly_expired_i,
  input  logic [`IRQ_DLY_W-1:0]  lfsr_low_i,
  output logic                   lfsr_step_o,
  output logic                   dly_load_o,
  output logic [`IRQ_DLY_W-1:0]  dly_value_o,
  output logic                   sel_rnd_o,
  output logic                   lines_we_o,
  output logic                   lines_clr_o,
  output logic                   pc_sw_o,
  output logic                   irq_id_we_o
);
  import irq_gen_pkg::*;

  irq_state_e             state_q;
  irq_state_e             state_d;
  irq_state_e             state_cur;
  irq_state_e             entry_state;
  logic                   in_mode;
  logic [`IRQ_WORD_W-1:0] cap_q;
  logic                   cap_we;
  logic [`IRQ_DLY_W-1:0]  dly_span;
  logic                   id_we_q;

  //////////////////////////////////////////////////
  // Mode entry
  //////////////////////////////////////////////////

  // Does the stored state belong to the current mode
  always_comb begin
    unique case (mode_i)
      RANDOM: begin
        in_mode     = (state_q == DRAW) || (state_q == WAIT) || (state_q == HOLD);
        entry_state = DRAW;
      end
      PC_TRIG: begin
        in_mode     = (state_q == PC_WATCH) || (state_q == PC_ARMED);
        entry_state = PC_WATCH;
      end
      SOFTWARE_DEFINED: begin
        in_mode     = (state_q == SD_FOLLOW);
        entry_state = SD_FOLLOW;
      end
      default: begin
        in_mode     = (state_q == IDLE);
        entry_state = IDLE;
      end
    endcase
  end

  // A new mode acts in the same cycle it is seen
  assign state_cur = in_mode ? state_q : entry_state;

  //////////////////////////////////////////////////
  // Random delay
  //////////////////////////////////////////////////

  // Offset within the window is taken, anything larger saturates to max
  assign dly_span    = cfg_i.max_cycles - cfg_i.min_cycles;
  assign dly_value_o = (lfsr_low_i <= dly_span) ? cfg_i.min_cycles + lfsr_low_i
                                                : cfg_i.max_cycles;

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_cur;
    lfsr_step_o = 1'b0;
    dly_load_o  = 1'b0;
    sel_rnd_o   = 1'b0;
    lines_we_o  = 1'b0;
    pc_sw_o     = 1'b0;
    cap_we      = 1'b0;
    unique case (state_cur)
      DRAW: begin
        sel_rnd_o = 1'b1;
        // Keep stepping until the windowed word hits a mapped line
        if (word_nz_i) begin
          dly_load_o = 1'b1;
          state_d    = WAIT;
        end else begin
          lfsr_step_o = 1'b1;
        end
      end
      WAIT: begin
        // LFSR is frozen so the mapper still shows the drawn word
        sel_rnd_o = 1'b1;
        if (dly_expired_i) begin
          lines_we_o = 1'b1;
          state_d    = HOLD;
        end
      end
      HOLD: begin
        sel_rnd_o = 1'b1;
        // Move past the used word before the next draw
        if (irq_ack_i) begin
          lfsr_step_o = 1'b1;
          state_d     = DRAW;
        end
      end
      PC_WATCH: begin
        if (pc_valid_i && (pc_i == cfg_i.pc_trig)) begin
          pc_sw_o = 1'b1;
          cap_we  = 1'b1;
          state_d = PC_ARMED;
        end
      end
      PC_ARMED: begin
        // One-shot trigger, only line changes are tracked from here
        if (lines_i != cap_q) begin
          lines_we_o = 1'b1;
          cap_we     = 1'b1;
        end
      end
      SD_FOLLOW: begin
        // Zero word keeps the last pattern
        lines_we_o = (lines_i != '0);
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Acknowledge clears in every mode, STANDARD keeps lines at zero
  assign lines_clr_o = irq_ack_i || (mode_i == STANDARD);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      id_we_q <= 1'b0;
    end else begin
      state_q <= state_d;
      id_we_q <= irq_ack_i;
    end
  end

  // Snapshot of the software lines for change detection
  always_ff @(posedge clk_i) begin
    if (cap_we) begin
      cap_q <= lines_i;
    end
  end

  // Pulse lines up with the clearing edge
  assign irq_id_we_o = id_we_q;

endmodule

// File: irq_stim_gen.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module irq_stim_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  irq_gen_pkg::irq_mode_e  mode_i,
  input  irq_gen_pkg::irq_cfg_t   cfg_i,
  input  logic [31:0]             pc_i,
  input  logic                    pc_valid_i,
  input  logic [`IRQ_WORD_W-1:0]  lines_i,
  input  logic                    irq_ack_i,
  input  logic [5:0]              irq_ack_id_i,
  output irq_gen_pkg::irq_lines_t irq_lines_o,
  output logic                    irq_ack_o,
  output logic [5:0]              irq_act_id_o,
  output logic                    irq_id_we_o
);
  import irq_gen_pkg::*;

  // Id of the software line in the request word
  localparam logic [5:0] SW_ID = 6'd3;

  irq_mode_e              mode_q;
  irq_lines_t             lines_q;
  irq_lines_t             map_lines;
  irq_lines_t             sw_only;
  logic [5:0]             act_id_q;
  logic [5:0]             top_id;
  logic                   map_nz;
  logic [`IRQ_WORD_W-1:0] lfsr_word;
  logic [`IRQ_WORD_W-1:0] map_word;
  logic                   lfsr_step;
  logic                   dly_load;
  logic [`IRQ_DLY_W-1:0]  dly_value;
  logic                   dly_expired;
  logic                   sel_rnd;
  logic                   lines_we;
  logic                   lines_clr;
  logic                   pc_sw;

  //////////////////////////////////////////////////
  // Mode register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= STANDARD;
    end else begin
      mode_q <= mode_i;
    end
  end

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  irq_mode_fsm i_irq_mode_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mode_i        (mode_q),
    .cfg_i         (cfg_i),
    .pc_i          (pc_i),
    .pc_valid_i    (pc_valid_i),
    .lines_i       (lines_i),
    .irq_ack_i     (irq_ack_i),
    .word_nz_i     (map_nz),
    .dly_expired_i (dly_expired),
    .lfsr_low_i    (lfsr_word[`IRQ_DLY_W-1:0]),
    .lfsr_step_o   (lfsr_step),
    .dly_load_o    (dly_load),
    .dly_value_o   (dly_value),
    .sel_rnd_o     (sel_rnd),
    .lines_we_o    (lines_we),
    .lines_clr_o   (lines_clr),
    .pc_sw_o       (pc_sw),
    .irq_id_we_o   (irq_id_we_o)
  );

  irq_delay_timer i_irq_delay_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (dly_load),
    .value_i   (dly_value),
    .expired_o (dly_expired)
  );

  irq_lfsr_word i_irq_lfsr_word (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .step_i (lfsr_step),
    .word_o (lfsr_word)
  );

  // Random word in RANDOM, software word otherwise
  assign map_word = sel_rnd ? lfsr_word : lines_i;

  irq_line_mapper i_irq_line_mapper (
    .word_i      (map_word),
    .apply_win_i (sel_rnd),
    .min_id_i    (cfg_i.min_id),
    .max_id_i    (cfg_i.max_id),
    .lines_o     (map_lines),
    .nz_o        (map_nz),
    .top_id_o    (top_id)
  );

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // PC trigger raises the software line alone
  always_comb begin
    sw_only    = '0;
    sw_only.sw = 1'b1;
  end

  // Clear has priority over any set or load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lines_q <= '0;
    end else if (lines_clr) begin
      lines_q <= '0;
    end else if (pc_sw) begin
      lines_q <= sw_only;
    end else if (lines_we) begin
      lines_q <= map_lines;
    end
  end

  // Carries the core's acknowledged id while irq_id_we_o is high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      act_id_q <= '0;
    end else if (mode_q == STANDARD) begin
      act_id_q <= '0;
    end else if (irq_ack_i) begin
      act_id_q <= irq_ack_id_i;
    end else if (pc_sw) begin
      act_id_q <= SW_ID;
    end else if (lines_we) begin
      act_id_q <= top_id;
    end
  end

  assign irq_lines_o  = lines_q;
  assign irq_act_id_o = act_id_q;
  // Acknowledge goes straight back to the core
  assign irq_ack_o    = irq_ack_i;

endmodule

// File: tb_irq_stim_gen.sv
`timescale 1ns/10ps
`include "irq_gen_cfg.svh"

module tb_irq_stim_gen;
  import irq_gen_pkg::*;

  // Rough length of all tests in cycles
  // Random draws dominate
  localparam int TEST_CYCLES = 1600;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 2000;

  logic                   clk_i;
  logic                   rst_ni;
  irq_mode_e              mode_i;
  irq_cfg_t               cfg_i;
  logic [31:0]            pc_i;
  logic                   pc_valid_i;
  logic [`IRQ_WORD_W-1:0] lines_i;
  logic                   irq_ack_i;
  logic [5:0]             irq_ack_id_i;
  irq_lines_t             irq_lines_o;
  logic                   irq_ack_o;
  logic [5:0]             irq_act_id_o;
  logic                   irq_id_we_o;

  int value_errs;
  int other_errs;
  int cycle_cnt;

  irq_stim_gen i_irq_stim_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mode_i       (mode_i),
    .cfg_i        (cfg_i),
    .pc_i         (pc_i),
    .pc_valid_i   (pc_valid_i),
    .lines_i      (lines_i),
    .irq_ack_i    (irq_ack_i),
    .irq_ack_id_i (irq_ack_id_i),
    .irq_lines_o  (irq_lines_o),
    .irq_ack_o    (irq_ack_o),
    .irq_act_id_o (irq_act_id_o),
    .irq_id_we_o  (irq_id_we_o)
  );

  //////////////////////////////////////////////////
  // Clock and cycle limit
  //////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
      $display("Errors: %0d value, %0d other", value_errs, other_errs);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model of the mapping rule
  //////////////////////////////////////////////////

  // Word bit to core line
  function automatic irq_lines_t fold_word(input logic [63:0] w);
    irq_lines_t l;
    l.sw    = w[3];
    l.timer = w[7];
    l.ext   = w[11];
    l.fast  = w[30:16];
    l.nmi   = w[31];
    l.fastx = w[63:32];
    return l;
  endfunction

  // Core lines back to their word ids
  function automatic logic [63:0] unfold_lines(input irq_lines_t l);
    logic [63:0] w;
    w        = '0;
    w[3]     = l.sw;
    w[7]     = l.timer;
    w[11]    = l.ext;
    w[30:16] = l.fast;
    w[31]    = l.nmi;
    w[63:32] = l.fastx;
    return w;
  endfunction

  function automatic logic [5:0] highest_id(input logic [63:0] w);
    logic [5:0] id;
    id = '0;
    for (int i = 0; i < 64; i++) begin
      if (w[i]) begin
        id = 6'(i);
      end
    end
    return id;
  endfunction

  function automatic logic [63:0] window_mask(input logic [5:0] lo, input logic [5:0] hi);
    logic [63:0] m;
    for (int i = 0; i < 64; i++) begin
      m[i] = (i >= lo) && (i <= hi);
    end
    return m;
  endfunction

  function automatic logic [63:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("FAILED at %0t ns: %s", $time, msg);
      value_errs++;
    end
  endtask

  // Returns right after the edge where mode_q takes the new value
  task automatic enter_mode(input irq_mode_e m);
    @(posedge clk_i);
    mode_i <= m;
    @(posedge clk_i);
  endtask

  // Leaving a mode clears the lines one edge after mode_q changes
  task automatic go_standard();
    enter_mode(STANDARD);
    @(posedge clk_i);
    @(negedge clk_i);
    check(irq_lines_o == '0, "lines not cleared after return to STANDARD");
  endtask

  // One-cycle acknowledge
  // Ends at the negedge after the edge that follows the clear
  task automatic pulse_ack(input string where);
    @(posedge clk_i);
    irq_ack_i    <= 1'b1;
    irq_ack_id_i <= 6'($urandom);
    @(negedge clk_i);
    check(irq_ack_o === 1'b1, $sformatf("%s: irq_ack_o does not follow irq_ack_i", where));
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
    check(irq_lines_o == '0, $sformatf("%s: lines not cleared by ack", where));
    check(irq_id_we_o === 1'b1, $sformatf("%s: no id write pulse after ack", where));
    check(irq_ack_o === 1'b0, $sformatf("%s: irq_ack_o stuck high", where));
    @(posedge clk_i);
    @(negedge clk_i);
    check(irq_id_we_o === 1'b0, $sformatf("%s: id write pulse longer than 1 cycle", where));
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic standard_stays_clear();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      lines_i    <= rand_word();
      pc_valid_i <= 1'b1;
      pc_i       <= cfg_i.pc_trig;
      @(negedge clk_i);
      check(irq_lines_o == '0, "STANDARD: lines set");
      check(irq_id_we_o === 1'b0, "STANDARD: id write pulse without ack");
      check(irq_act_id_o == '0, "STANDARD: active id not zero");
    end
    @(posedge clk_i);
    pc_valid_i <= 1'b0;
    lines_i    <= '0;
    pulse_ack("STANDARD");
  endtask

  task automatic software_word_follow();
    logic [63:0] w;
    enter_mode(SOFTWARE_DEFINED);
    for (int i = 0; i < 10; i++) begin
      w = rand_word();
      @(posedge clk_i);
      lines_i <= w;
      @(posedge clk_i);
      @(negedge clk_i);
      check(irq_lines_o == fold_word(w),
            $sformatf("SD: word %h gives lines %h", w, irq_lines_o));
    end
    // Zero word holds the last pattern
    @(posedge clk_i);
    lines_i <= '0;
    repeat (3) @(negedge clk_i);
    check(irq_lines_o == fold_word(w), "SD: zero word did not hold last lines");
    pulse_ack("SD");
    check(irq_lines_o == '0, "SD: lines came back after ack");
    // Leave with a pattern on the lines so the exit clear is visible
    @(posedge clk_i);
    lines_i <= w;
    @(posedge clk_i);
    @(negedge clk_i);
    check(irq_lines_o == fold_word(w), "SD: word after ack not loaded");
    go_standard();
    @(posedge clk_i);
    lines_i <= '0;
  endtask

  // Counts edges from the end of DRAW until the lines assert
  task automatic random_draw(input irq_cfg_t c, input bit exact, output bit ok);
    int          n;
    int          limit;
    logic [63:0] w;
    limit = int'(c.max_cycles) + 64;
    n     = 0;
    do begin
      @(posedge clk_i);
      n++;
      @(negedge clk_i);
    end while ((irq_lines_o == '0) && (n < limit));
    ok = (irq_lines_o != '0);
    assert (ok) else begin
      $display("Random mode: lines never asserted within %0d cycles", limit);
      other_errs++;
    end
    if (ok) begin
      w = unfold_lines(irq_lines_o);
      check((w & ~window_mask(c.min_id, c.max_id)) == '0,
            $sformatf("RANDOM: word %h outside ids %0d..%0d", w, c.min_id, c.max_id));
      check(irq_act_id_o == highest_id(w),
            $sformatf("RANDOM: act id %0d, expected %0d", irq_act_id_o, highest_id(w)));
      if (exact) begin
        check(n == int'(c.min_cycles) + 1,
              $sformatf("RANDOM: delay %0d, expected %0d", n, c.min_cycles + 1));
      end else begin
        check((n >= int'(c.min_cycles) + 1) && (n <= int'(c.max_cycles) + 1),
              $sformatf("RANDOM: delay %0d outside %0d..%0d", n, c.min_cycles + 1,
                        c.max_cycles + 1));
      end
      // Held until acknowledged
      repeat (3) @(negedge clk_i);
      check(unfold_lines(irq_lines_o) == w, "RANDOM: lines not held before ack");
    end
  endtask

  task automatic run_random(input int groups, input int draws, input bit exact);
    irq_cfg_t c;
    bit       ok;
    for (int g = 0; g < groups; g++) begin
      // Wide windows keep the first draw nonzero in practice
      c.min_id     = 6'(16 + $urandom_range(0, 24));
      c.max_id     = c.min_id + 6'(15 + $urandom_range(0, 48 - int'(c.min_id)));
      c.min_cycles = 16'($urandom_range(0, 20));
      c.max_cycles = exact ? c.min_cycles : c.min_cycles + 16'($urandom_range(0, 30));
      c.pc_trig    = $urandom;
      @(posedge clk_i);
      cfg_i <= c;
      enter_mode(RANDOM);
      // DRAW occupies the cycle after mode entry
      @(posedge clk_i);
      for (int d = 0; d < draws; d++) begin
        random_draw(c, exact, ok);
        if (!ok) break;
        pulse_ack("RANDOM");
      end
      go_standard();
    end
  endtask

  task automatic pc_trigger_sequence();
    logic [31:0] trig;
    logic [63:0] w0;
    logic [63:0] w1;
    irq_lines_t  sw_line;
    trig       = 32'h0000_4C80;
    w0         = rand_word();
    w1         = ~w0;
    sw_line    = '0;
    sw_line.sw = 1'b1;
    @(posedge clk_i);
    cfg_i.pc_trig <= trig;
    lines_i       <= w0;
    enter_mode(PC_TRIG);
    // Wrong address
    @(posedge clk_i);
    pc_valid_i <= 1'b1;
    pc_i       <= trig ^ 32'h4;
    @(posedge clk_i);
    pc_valid_i <= 1'b0;
    @(negedge clk_i);
    check(irq_lines_o == '0, "PC: non-matching pc changed the lines");
    // Matching address raises sw alone
    @(posedge clk_i);
    pc_valid_i <= 1'b1;
    pc_i       <= trig;
    @(posedge clk_i);
    pc_valid_i <= 1'b0;
    @(negedge clk_i);
    check(irq_lines_o == sw_line, $sformatf("PC: lines %h after match", irq_lines_o));
    repeat (2) @(negedge clk_i);
    check(irq_lines_o == sw_line, "PC: sw line not held");
    // Software lines take over once they change
    @(posedge clk_i);
    lines_i <= w1;
    @(posedge clk_i);
    @(negedge clk_i);
    check(irq_lines_o == fold_word(w1), $sformatf("PC: lines %h after change", irq_lines_o));
    // Second match is ignored
    @(posedge clk_i);
    pc_valid_i <= 1'b1;
    pc_i       <= trig;
    @(posedge clk_i);
    pc_valid_i <= 1'b0;
    @(negedge clk_i);
    check(irq_lines_o == fold_word(w1), "PC: second match re-triggered");
    pulse_ack("PC");
    check(irq_lines_o == '0, "PC: lines came back after ack");
    go_standard();
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(95));
    value_errs   = 0;
    other_errs   = 0;
    cycle_cnt    = 0;
    rst_ni       = 1'b0;
    mode_i       = STANDARD;
    cfg_i        = '0;
    pc_i         = '0;
    pc_valid_i   = 1'b0;
    lines_i      = '0;
    irq_ack_i    = 1'b0;
    irq_ack_id_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check(irq_lines_o == '0, "reset: lines not zero");
    check(irq_id_we_o === 1'b0, "reset: id write enable high");
    check(irq_act_id_o == '0, "reset: active id not zero");

    standard_stays_clear();
    software_word_follow();
    run_random(5, 4, 1'b0);
    // Equal bounds fix the delay
    run_random(1, 3, 1'b1);
    pc_trigger_sequence();

    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
irq_gen_pkg.sv
irq_lfsr_word.sv
irq_delay_timer.sv
irq_line_mapper.sv
irq_mode_fsm.sv
irq_stim_gen.sv
tb_irq_stim_gen.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_irq_stim_gen
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
